//--- entropy_pack_pkg.sv
// ==================================================
// widths and bus structs of the entropy pack back end
// tokens are at most 27 bits, words are 32 bits
// every code, amplitude and length field is unsigned
// ==================================================
package entropy_pack_pkg;

    localparam int code_w  = 16;                 // huffman code width
    localparam int extra_w = 11;                 // amplitude width
    localparam int tok_w   = 27;                 // merged token width
    localparam int len_w   = 5;                  // token and code length field
    localparam int xlen_w  = 4;                  // amplitude length field
    localparam int word_w  = 32;                 // output word width
    localparam int bytes_w = 3;                  // byte count of a flush word

    localparam logic [len_w-1:0] tok_len_max = len_w'(tok_w); // longest token

    // barrel shifter widths inside the stuffer
    localparam int sh1_w = tok_w + 24;           // after the byte shift
    localparam int sh2_w = tok_w + 30;           // after the 2-bit shift
    localparam int sh3_w = tok_w + 31;           // after the 1-bit shift
    localparam int ovf_w = sh3_w - word_w;       // bits that spill into the next word

    // one input symbol, both parts lsb aligned
    typedef struct packed {
        logic [code_w-1:0]  code;                // huffman code
        logic [len_w-1:0]   code_len;            // 1..16
        logic [extra_w-1:0] extra;               // bits above extra_len are junk
        logic [xlen_w-1:0]  extra_len;           // 0..11
    } huff_sym_t;

    typedef struct packed {
        logic [tok_w-1:0] data;                  // msb aligned, zero below len
        logic [len_w-1:0] len;                   // 1..27
    } stuff_token_t;

    typedef struct packed {
        logic [word_w-1:0]  data;                // msb is the oldest bit
        logic [bytes_w-1:0] bytes;               // 0 on a full word
    } packed_word_t;

endpackage

//--- huff_token_merge.sv
// ==================================================
// joins a huffman code and its amplitude bits
// into one msb aligned token, one cycle of latency
// code_len plus extra_len must not exceed 27
// code bits above code_len are expected to be zero
// ==================================================
module huff_token_merge (
    input  logic                           xclk,
    input  logic                           rst,
    input  entropy_pack_pkg::huff_sym_t    sym,         // code and amplitude, lsb aligned
    input  logic                           sym_valid,
    input  logic                           flush_in,    // never together with sym_valid
    output entropy_pack_pkg::stuff_token_t token,
    output logic                           token_valid,
    output logic                           flush_tok    // flush kept in line with tokens
);

    logic [entropy_pack_pkg::extra_w-1:0] extra_mask;  // ones below extra_len
    logic [entropy_pack_pkg::extra_w-1:0] extra_clean;
    logic [entropy_pack_pkg::len_w-1:0]   tok_len;
    logic [entropy_pack_pkg::len_w-1:0]   code_sh;     // free bits under the code
    logic [entropy_pack_pkg::len_w-1:0]   extra_sh;    // free bits under the amplitude
    logic [entropy_pack_pkg::tok_w-1:0]   code_top;
    logic [entropy_pack_pkg::tok_w-1:0]   extra_top;

    // drop the junk above extra_len, all ones survive a shift by 11
    assign extra_mask  = ~({entropy_pack_pkg::extra_w{1'b1}} << sym.extra_len);
    assign extra_clean = sym.extra & extra_mask;

    assign tok_len  = sym.code_len + {1'b0, sym.extra_len}; // at most 27
    assign code_sh  = entropy_pack_pkg::tok_len_max - sym.code_len;
    assign extra_sh = entropy_pack_pkg::tok_len_max - tok_len;

    // code goes to the top of the field
    assign code_top = {{(entropy_pack_pkg::tok_w - entropy_pack_pkg::code_w){1'b0}},
                       sym.code} << code_sh;

    // amplitude sits right under the code
    assign extra_top = {{(entropy_pack_pkg::tok_w - entropy_pack_pkg::extra_w){1'b0}},
                        extra_clean} << extra_sh;

    always_ff @(posedge xclk) begin
        if (rst) begin
            token_valid <= 1'b0;
            flush_tok   <= 1'b0;
        end else begin
            token_valid <= sym_valid;
            flush_tok   <= flush_in;                // same delay as the tokens
        end
    end

    // token payload only moves with a symbol
    always_ff @(posedge xclk) begin
        if (sym_valid) begin
            token.data <= code_top | extra_top;     // no overlap once masked
            token.len  <= tok_len;
        end
    end

endmodule

//--- bit_stuffer_27_32.sv
// ==================================================
// packs msb aligned 1..27 bit tokens into 32-bit words
// three cycles from token or flush to dv and flush_out
// token bits below len must be zero, no back-pressure
// a flush never comes in the same cycle as a token
// ==================================================
module bit_stuffer_27_32 (
    input  logic                           xclk,
    input  logic                           rst,
    input  entropy_pack_pkg::stuff_token_t token,       // msb aligned, zero below len
    input  logic                           token_valid,
    input  logic                           flush_in,    // handled as a zero-length item
    output entropy_pack_pkg::packed_word_t word,
    output logic                           dv,
    output logic                           flush_out
);

    typedef struct packed {
        logic                               tok;   // token in this stage
        logic                               fl;    // flush in this stage
        logic                               carry; // item completes a word
        logic [entropy_pack_pkg::len_w-1:0] pos;   // fill position before the item
    } stage_ctl_t;

    logic [entropy_pack_pkg::len_w-1:0]  fill_pos;  // bits pending, mod 32
    logic [entropy_pack_pkg::len_w:0]    fill_sum;  // msb is the word carry
    stage_ctl_t                          ctl1;
    stage_ctl_t                          ctl2;
    logic [entropy_pack_pkg::sh1_w-1:0]  data1;
    logic [entropy_pack_pkg::sh2_w-1:0]  data2;
    logic [entropy_pack_pkg::word_w-1:0] mask2;     // ones where new bits land
    logic [entropy_pack_pkg::sh3_w-1:0]  data3;
    logic [entropy_pack_pkg::word_w-1:0] hold;      // partial word being built
    logic [entropy_pack_pkg::word_w-1:0] merged;
    logic [entropy_pack_pkg::len_w:0]    bits_up;   // pending bits rounded toward bytes

    assign fill_sum = {1'b0, fill_pos} + {1'b0, token.len};

    // stage 1, position bookkeeping and the byte shift
    always_ff @(posedge xclk) begin
        if (rst) begin
            fill_pos <= '0;
            ctl1     <= '0;
        end else begin
            if (flush_in) begin
                fill_pos <= '0;                         // next token starts at bit 31
            end else if (token_valid) begin
                fill_pos <= fill_sum[entropy_pack_pkg::len_w-1:0];
            end
            ctl1.tok   <= token_valid;
            ctl1.fl    <= flush_in;
            ctl1.carry <= token_valid & fill_sum[entropy_pack_pkg::len_w];
            ctl1.pos   <= fill_pos;                     // pending count for a flush
        end
    end

    always_ff @(posedge xclk) begin
        if (token_valid) begin
            case (fill_pos[4:3])
                2'd0: data1 <= {       token.data, 24'b0};
                2'd1: data1 <= { 8'b0, token.data, 16'b0};
                2'd2: data1 <= {16'b0, token.data,  8'b0};
                2'd3: data1 <= {24'b0, token.data       };
            endcase
        end
    end

    // stage 2, the 2-bit shift and the merge mask
    always_ff @(posedge xclk) begin
        if (rst) begin
            ctl2 <= '0;
        end else begin
            ctl2 <= ctl1;
        end
    end

    always_ff @(posedge xclk) begin
        if (ctl1.tok) begin
            case (ctl1.pos[2:1])
                2'd0: data2 <= {      data1, 6'b0};
                2'd1: data2 <= { 2'b0, data1, 4'b0};
                2'd2: data2 <= { 4'b0, data1, 2'b0};
                2'd3: data2 <= { 6'b0, data1      };
            endcase
        end
        if (ctl1.tok || ctl1.fl) begin
            mask2 <= {entropy_pack_pkg::word_w{1'b1}} >> ctl1.pos; // flush needs it too
        end
    end

    // stage 3, the 1-bit shift merged into the hold register
    assign data3  = ctl2.pos[0] ? {1'b0, data2} : {data2, 1'b0};
    assign merged = (hold & ~mask2)
                  | (data3[entropy_pack_pkg::sh3_w-1 -: entropy_pack_pkg::word_w] & mask2);
    assign bits_up = {1'b0, ctl2.pos} + 6'd7;

    always_ff @(posedge xclk) begin
        if (ctl2.tok) begin
            if (ctl2.carry) begin
                // spilled bits open the next word
                hold <= {data3[entropy_pack_pkg::ovf_w-1:0],
                         {(entropy_pack_pkg::word_w - entropy_pack_pkg::ovf_w){1'b0}}};
            end else begin
                hold <= merged;
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (ctl2.tok && ctl2.carry) begin
            word.data  <= merged;                       // full word
            word.bytes <= '0;
        end else if (ctl2.fl) begin
            word.data  <= hold & ~mask2;                // pending bits, zero fill
            word.bytes <= bits_up[entropy_pack_pkg::len_w -: entropy_pack_pkg::bytes_w];
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            dv        <= 1'b0;
            flush_out <= 1'b0;
        end else begin
            dv        <= (ctl2.tok & ctl2.carry) | (ctl2.fl & (ctl2.pos != '0));
            flush_out <= ctl2.fl;                       // pulses even with nothing pending
        end
    end

endmodule

//--- entropy_pack_top.sv
// ==================================================
// symbol to 32-bit word packer, four cycles deep
// flush_in must not share a cycle with sym_valid
// every word must be taken, there is no stall
// ==================================================
module entropy_pack_top (
    input  logic                           xclk,
    input  logic                           rst,
    input  entropy_pack_pkg::huff_sym_t    sym,
    input  logic                           sym_valid,   // may strobe every cycle
    input  logic                           flush_in,    // one-cycle pulse
    output entropy_pack_pkg::packed_word_t word,
    output logic                           dv,
    output logic                           flush_out
);

    entropy_pack_pkg::stuff_token_t token;              // merged code and amplitude
    logic                           token_valid;
    logic                           flush_tok;          // flush delayed with the tokens

    huff_token_merge u_merge (
        .xclk        (xclk),
        .rst         (rst),
        .sym         (sym),
        .sym_valid   (sym_valid),
        .flush_in    (flush_in),
        .token       (token),
        .token_valid (token_valid),
        .flush_tok   (flush_tok)
    );

    bit_stuffer_27_32 u_stuff (
        .xclk        (xclk),
        .rst         (rst),
        .token       (token),
        .token_valid (token_valid),
        .flush_in    (flush_tok),
        .word        (word),
        .dv          (dv),
        .flush_out   (flush_out)
    );

endmodule

//--- tb_pack_model.sv
// ==================================================
// bit-level reference for the entropy packer
// inputs and outputs are sampled on the falling edge
// each result is due four falling edges after its strobe
// sym_valid and flush_in must never share a cycle
// ==================================================
module tb_pack_model (
    input  logic                           xclk,
    input  logic                           rst,
    input  entropy_pack_pkg::huff_sym_t    sym,
    input  logic                           sym_valid,
    input  logic                           flush_in,
    input  entropy_pack_pkg::packed_word_t word,
    input  logic                           dv,
    input  logic                           flush_out,
    output logic                           mismatch,    // set at the first error
    output logic                           busy         // results still due
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int latency = 4;                         // strobe to dv in cycles

    typedef struct packed {
        entropy_pack_pkg::packed_word_t w;              // expected word
        logic                           has_word;       // dv expected
        logic                           fl;             // flush_out expected
        int                             due;            // cycle the result shows up
    } exp_item_t;

    bit        bits_q[$];                               // stream bits not yet in a word
    exp_item_t exp_q[$];                                // results in arrival order
    int        cyc = 0;

    task automatic report_error(input string msg);
        if (mismatch !== 1'b1) begin                    // only the first one is printed
            $display("%s", msg);
            mismatch = 1'b1;
        end
    endtask

    task automatic check_word(input entropy_pack_pkg::packed_word_t got,
                              input entropy_pack_pkg::packed_word_t exp);
        if (got.data !== exp.data) begin
            report_error($sformatf("[FAIL] word.data expected 0x%h got 0x%h",
                                   exp.data, got.data));
        end else if (got.bytes !== exp.bytes) begin
            report_error($sformatf("[FAIL] word.bytes expected 0x%h got 0x%h",
                                   exp.bytes, got.bytes));
        end
    endtask

    task automatic check_flush(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] flush_out expected 0x%h got 0x%h", exp, got));
        end
    endtask

    task automatic check_outputs();
        exp_item_t it;
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            it = exp_q.pop_front();
            if (it.has_word && dv !== 1'b1) begin
                report_error($sformatf("expected word did not come out at cycle %0d", cyc));
            end else if (!it.has_word && dv !== 1'b0) begin
                report_error($sformatf("flush with nothing pending gave a word at cycle %0d",
                                       cyc));
            end else if (it.has_word) begin
                check_word(word, it.w);
            end
            check_flush(flush_out, it.fl);
        end else begin
            if (dv !== 1'b0) report_error($sformatf("dv came with no word due at cycle %0d", cyc));
            if (flush_out !== 1'b0) report_error("flush_out came with no flush due");
        end
    endtask

    // code bits first, then the low extra_len amplitude bits, msb first
    task automatic add_symbol(input entropy_pack_pkg::huff_sym_t s);
        exp_item_t it;
        for (int i = int'(s.code_len) - 1; i >= 0; i--) bits_q.push_back(s.code[i[3:0]]);
        for (int i = int'(s.extra_len) - 1; i >= 0; i--) bits_q.push_back(s.extra[i[3:0]]);
        if (bits_q.size() >= 32) begin
            it.w.bytes  = '0;                           // full word
            it.has_word = 1'b1;
            it.fl       = 1'b0;
            it.due      = cyc + latency;
            for (int i = 31; i >= 0; i--) it.w.data[i[4:0]] = bits_q.pop_front();
            exp_q.push_back(it);
        end
    endtask

    task automatic add_flush();
        exp_item_t it;
        int        n;
        n           = bits_q.size();                    // never 32 here
        it.w        = '0;                               // zero fill below the pending bits
        it.w.bytes  = 3'((n + 7) / 8);
        it.has_word = (n != 0);
        it.fl       = 1'b1;
        it.due      = cyc + latency;
        for (int i = 31; i >= 32 - n; i--) it.w.data[i[4:0]] = bits_q.pop_front();
        exp_q.push_back(it);
    endtask

    always @(negedge xclk) begin
        cyc = cyc + 1;
        if (rst) begin
            bits_q.delete();                            // fill position back to zero
            exp_q.delete();
            if (dv !== 1'b0 || flush_out !== 1'b0) report_error("dv or flush_out high in reset");
        end else begin
            check_outputs();
            if (sym_valid === 1'b1) add_symbol(sym);
            else if (flush_in === 1'b1) add_flush();
        end
        busy = (exp_q.size() != 0);
    end

endmodule

//--- tb_entropy_pack.sv
// ==================================================
// testbench for entropy_pack_top
// seeded random symbols with gaps, flushes, resets
// expected words and flush pulses from tb_pack_model
// ==================================================
module tb_entropy_pack;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_b2b      = 200;                    // back to back symbols
    localparam int n_bursts   = 20;
    localparam int burst_max  = 8;                      // symbols per burst
    localparam int n_flushes  = 15;
    localparam int run_max    = 10;                     // symbols ahead of a flush
    localparam int n_bounds   = 6;                      // word boundary flushes
    localparam int sym_budget = n_b2b + n_bursts * burst_max + n_flushes * run_max
                              + n_bounds * 12 + 24;     // upper bound on symbols sent
    localparam int wd_cycles  = 8 * sym_budget + 100;

    logic                           xclk = 1'b0;        // low before any process runs
    logic                           rst;
    entropy_pack_pkg::huff_sym_t    sym;
    logic                           sym_valid;
    logic                           flush_in;
    entropy_pack_pkg::packed_word_t word;
    logic                           dv;
    logic                           flush_out;
    logic                           mismatch;
    logic                           busy;
    int                             sent_bits;          // stream bits mod 32 since last flush

    entropy_pack_top u_dut (
        .xclk      (xclk),
        .rst       (rst),
        .sym       (sym),
        .sym_valid (sym_valid),
        .flush_in  (flush_in),
        .word      (word),
        .dv        (dv),
        .flush_out (flush_out)
    );

    tb_pack_model u_model (
        .xclk      (xclk),
        .rst       (rst),
        .sym       (sym),
        .sym_valid (sym_valid),
        .flush_in  (flush_in),
        .word      (word),
        .dv        (dv),
        .flush_out (flush_out),
        .mismatch  (mismatch),
        .busy      (busy)
    );

    initial begin
        forever #2 xclk = ~xclk;                        // 4 ns period
    end

    initial begin
        repeat (wd_cycles) @(posedge xclk);
        $display("tests failed");
        $fatal(1, "watchdog ran out after %0d cycles", wd_cycles);
    end

    initial begin
        wait (mismatch === 1'b1);
        $display("tests failed");
        $fatal(1, "stopped at the first mismatch");
    end

    // len 0 picks both lengths freely
    function automatic entropy_pack_pkg::huff_sym_t make_sym(input int len);
        entropy_pack_pkg::huff_sym_t s;
        int                          lo;
        int                          hi;
        int                          cl;
        int                          xl;
        if (len == 0) begin
            cl = 1 + int'($urandom % 16);
            xl = int'($urandom % 12);                   // extra_len 0 included
        end else begin
            lo = (len > 11) ? len - 11 : 1;             // split len into code and amplitude
            hi = (len > 16) ? 16 : len;
            cl = lo + int'($urandom % (hi - lo + 1));
            xl = len - cl;
        end
        s.code_len  = 5'(cl);
        s.extra_len = 4'(xl);
        s.code      = 16'($urandom & ((32'h1 << cl) - 1)); // zero above code_len
        s.extra     = 11'($urandom);                    // junk above extra_len
        return s;
    endfunction

    task automatic send_sym(input int len);
        entropy_pack_pkg::huff_sym_t s;
        s         = make_sym(len);
        sent_bits = (sent_bits + int'(s.code_len) + int'(s.extra_len)) % 32;
        @(posedge xclk);
        sym       <= s;
        sym_valid <= 1'b1;
        flush_in  <= 1'b0;
    endtask

    task automatic send_flush();
        sent_bits = 0;
        @(posedge xclk);
        sym_valid <= 1'b0;
        flush_in  <= 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge xclk);
            sym_valid <= 1'b0;
            flush_in  <= 1'b0;
        end
    endtask

    task automatic hold_reset();
        sent_bits = 0;
        rst       <= 1'b1;
        sym_valid <= 1'b0;
        flush_in  <= 1'b0;
        repeat (4) @(posedge xclk);
        rst <= 1'b0;
    endtask

    // top the stream up to the next multiple of 32 bits
    task automatic fill_to_boundary();
        int r;
        while (sent_bits != 0) begin
            r = 32 - sent_bits;
            send_sym((r > 27) ? 1 + int'($urandom % 16) : r);
        end
    endtask

    initial begin
        void'($urandom(32'h3e03_272f));
        sym       <= '0;
        sym_valid <= 1'b0;
        flush_in  <= 1'b0;
        hold_reset();
        idle(2);

        repeat (n_b2b) send_sym(0);                     // keeps four items in flight

        repeat (n_bursts) begin                         // bursts with idle gaps
            repeat (1 + $urandom % burst_max) send_sym(0);
            idle(1 + int'($urandom % 6));
        end

        repeat (n_flushes) begin                        // flush with bits pending
            repeat (1 + $urandom % run_max) send_sym(0);
            send_flush();
            if ($urandom % 2 == 0) idle(1 + int'($urandom % 3));
        end

        repeat (n_bounds) begin                         // exact word boundary then a second flush
            repeat ($urandom % 6) send_sym(0);
            fill_to_boundary();
            send_flush();
            send_flush();
        end

        repeat (5) send_sym(0);                         // leave bits pending across a reset
        idle(8);
        hold_reset();
        repeat (12) send_sym(0);
        send_flush();

        idle(2);
        while (busy !== 1'b0) @(posedge xclk);          // last result checked
        idle(8);                                        // room for a stray dv
        if (mismatch === 1'b1) begin
            $display("tests failed");
            $fatal(1, "mismatch seen before the end of the run");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

//--- entropy_pack.f
entropy_pack_pkg.sv
huff_token_merge.sv
bit_stuffer_27_32.sv
entropy_pack_top.sv
tb_pack_model.sv
tb_entropy_pack.sv

//--- Makefile
# Verilator build and run of the entropy packer testbench
# pass or fail is the exit status of the simulation binary

VERILATOR ?= verilator
TOP       ?= tb_entropy_pack
FLIST     ?= entropy_pack.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
SIM_ARGS  ?=

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
